// File: common/strm_pkg.sv
`default_nettype none

package strm_pkg;

   // ==========================================================
   // widths and sizes
   // ==========================================================
   localparam int ADDR_W          = 32;  // byte address
   localparam int STRIP_W         = 64;  // one strip of read data
   localparam int TID_W           = 13;  // response transaction id
   localparam int LEN_W           = 6;   // strips per burst, 0 reads as 1

   localparam int STRIP_BYTES     = 8;                     // address step per strip
   localparam int STRIP_OFS       = $clog2(STRIP_BYTES);   // byte offset bits inside a strip

   localparam int RAM_DEPTH_LOG2  = 8;
   localparam int RAM_DEPTH       = 1 << RAM_DEPTH_LOG2;   // 256 strips

   localparam int FIFO_DEPTH_LOG2 = 4;
   localparam int FIFO_DEPTH      = 1 << FIFO_DEPTH_LOG2;  // 16 entries
   // almost full rises once fewer than this many entries are free
   localparam int FIFO_AF_FREE    = 3;

   // ==========================================================
   // vector types
   // ==========================================================
   typedef logic [ADDR_W-1:0]         addr_t;
   typedef logic [STRIP_W-1:0]        strip_t;
   typedef logic [TID_W-1:0]          tid_t;
   typedef logic [LEN_W-1:0]          len_t;
   typedef logic [RAM_DEPTH_LOG2-1:0] ram_adr_t;
   typedef logic [FIFO_DEPTH_LOG2:0]  fifo_ptr_t;  // one extra bit tells full from empty

   // all stream responses share this id, transaction number 0 means burst response
   localparam tid_t STREAM_TID = {6'h3f, {(TID_W - 6){1'b0}}};

   // burst request from the master
   typedef struct packed {
      addr_t adr;   // byte address of the first strip
      len_t  len;   // strip count
   } burst_cmd_t;

   // one strip on its way back to the master
   typedef struct packed {
      tid_t   tid;
      addr_t  adr;
      strip_t dat;
      logic   last;  // set on the final strip of the burst only
   } strip_resp_t;

   typedef enum logic {
      IDLE,
      READ
   } reader_state_t;

endpackage

`default_nettype wire

// File: project.f
common/strm_pkg.sv
strm_fifo/async_fifo.sv
strm_fifo/strm_read_fifo.sv
verilog/strip_ram.sv
verilog/strm_burst_reader.sv
verilog/strm_read_top.sv
test/strm_checker.sv
test/tb_strm_read.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the stream read testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

TOP=tb_strm_read
LOG=sim.log

if ! verilator --binary --timing --top-module "$TOP" -f project.f -o "sim_$TOP"; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/"sim_$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q -x '>>> PASS' "$LOG"; then
   exit 0
fi
echo "simulation did not report success"
exit 1

// File: strm_fifo/async_fifo.sv
`default_nettype none

module async_fifo (
   input  wire                  rst,
   // write side, memory clock
   input  wire                  wclk,
   input  wire                  push,
   input  strm_pkg::strip_resp_t din,
   output logic                 almost_full,
   // read side, port clock
   input  wire                  rclk,
   input  wire                  pop,
   output strm_pkg::strip_resp_t dout,
   output logic                 empty
);
   import strm_pkg::*;

   function automatic fifo_ptr_t bin2gray(input fifo_ptr_t b);
      return b ^ (b >> 1);
   endfunction

   function automatic fifo_ptr_t gray2bin(input fifo_ptr_t g);
      fifo_ptr_t b;
      b[FIFO_DEPTH_LOG2] = g[FIFO_DEPTH_LOG2];  // msb passes straight through
      for (int i = FIFO_DEPTH_LOG2 - 1; i >= 0; i--) begin
         b[i] = b[i + 1] ^ g[i];
      end
      return b;
   endfunction

   strip_resp_t mem [FIFO_DEPTH];

   fifo_ptr_t wbin, wgray;      // write pointer, owned by wclk
   fifo_ptr_t rbin, rgray;      // read pointer, owned by rclk
   fifo_ptr_t rq1, rq2;         // read gray pointer seen in wclk
   fifo_ptr_t wq1, wq2;         // write gray pointer seen in rclk
   fifo_ptr_t rq_bin;           // synchronized read pointer back in binary
   fifo_ptr_t wr_count;         // fill level as the write side sees it
   fifo_ptr_t wbin_nxt, rbin_nxt;
   logic      full;
   logic      do_push, do_pop;

   // ==========================================================
   // write domain
   // ==========================================================
   assign rq_bin   = gray2bin(rq2);
   assign wr_count = wbin - rq_bin;            // can only overstate the level, never understate
   assign full     = (wr_count == fifo_ptr_t'(FIFO_DEPTH));
   assign almost_full = (wr_count > fifo_ptr_t'(FIFO_DEPTH - FIFO_AF_FREE));
   assign do_push  = push & ~full;             // a push into a full FIFO is dropped
   assign wbin_nxt = wbin + fifo_ptr_t'(1);

   always_ff @(posedge wclk) begin
      if (rst) begin
         wbin  <= '0;
         wgray <= '0;
      end else if (do_push) begin
         wbin  <= wbin_nxt;
         wgray <= bin2gray(wbin_nxt);
      end
   end

   always_ff @(posedge wclk) begin
      if (do_push) begin
         mem[wbin[FIFO_DEPTH_LOG2-1:0]] <= din;
      end
   end

   // two flop synchronizer for the read pointer
   always_ff @(posedge wclk) begin
      if (rst) begin
         rq1 <= '0;
         rq2 <= '0;
      end else begin
         rq1 <= rgray;   // only one bit changes per pop so the sample is coherent
         rq2 <= rq1;
      end
   end

   // ==========================================================
   // read domain
   // ==========================================================
   assign empty    = (rgray == wq2);  // stays high until the write is two rclk edges old
   assign do_pop   = pop & ~empty;
   assign rbin_nxt = rbin + fifo_ptr_t'(1);

   always_ff @(posedge rclk) begin
      if (rst) begin
         rbin  <= '0;
         rgray <= '0;
      end else if (do_pop) begin
         rbin  <= rbin_nxt;
         rgray <= bin2gray(rbin_nxt);
      end
   end

   // read data register, it only moves when an entry is popped
   always_ff @(posedge rclk) begin
      if (do_pop) begin
         dout <= mem[rbin[FIFO_DEPTH_LOG2-1:0]];
      end
   end

   // two flop synchronizer for the write pointer
   always_ff @(posedge rclk) begin
      if (rst) begin
         wq1 <= '0;
         wq2 <= '0;
      end else begin
         wq1 <= wgray;
         wq2 <= wq1;
      end
   end

endmodule

`default_nettype wire

// File: strm_fifo/strm_read_fifo.sv
`default_nettype none

module strm_read_fifo (
   input  wire                   rst,
   // strips from the burst reader, memory clock
   input  wire                   wclk,
   input  wire                   wr,
   input  strm_pkg::addr_t       wadr,
   input  strm_pkg::strip_t      wdat,
   input  wire                   last_strip,
   output logic                  almost_full,
   // responses to the master, port clock
   input  wire                   rclk,
   output strm_pkg::strip_resp_t resp,
   output logic                  resp_valid,
   input  wire                   resp_ready
);
   import strm_pkg::*;

   strip_resp_t cap;          // capture register in wclk
   logic        cap_valid;
   logic        empty;
   logic        pop;

   // ==========================================================
   // write side capture
   // ==========================================================
   // every strip gets the same id, the master only runs one stream at a time
   always_ff @(posedge wclk) begin
      if (wr) begin
         cap.tid  <= STREAM_TID;
         cap.adr  <= wadr;
         cap.dat  <= wdat;
         cap.last <= last_strip;
      end
   end

   always_ff @(posedge wclk) begin
      if (rst) begin
         cap_valid <= 1'b0;
      end else begin
         cap_valid <= wr;   // push goes out the cycle after wr
      end
   end

   // ==========================================================
   // clock crossing
   // ==========================================================
   // the FIFO read data register doubles as the response register
   async_fifo fifo_i (
      .rst         (rst),
      .wclk        (wclk),
      .push        (cap_valid),
      .din         (cap),
      .almost_full (almost_full),
      .rclk        (rclk),
      .pop         (pop),
      .dout        (resp),
      .empty       (empty)
   );

   // ==========================================================
   // read side output stage
   // ==========================================================
   // refill when the slot is empty or its strip is taken this edge
   assign pop = ~empty & (~resp_valid | resp_ready);

   always_ff @(posedge rclk) begin
      if (rst) begin
         resp_valid <= 1'b0;
      end else if (pop) begin
         resp_valid <= 1'b1;          // new strip lands in dout
      end else if (resp_ready) begin
         resp_valid <= 1'b0;          // taken with nothing behind it
      end
   end

endmodule

`default_nettype wire

// File: test/strm_checker.sv
`default_nettype none

module strm_checker (
   input  wire                   rclk,
   input  wire                   wclk,
   input  wire                   rst,
   // command handshake, memory clock
   input  wire                   cmd_valid,
   input  wire                   cmd_ready,
   // response port of the DUT
   input  strm_pkg::strip_resp_t resp,
   input  wire                   resp_valid,
   input  wire                   resp_ready,
   // expected strips, one per push
   input  strm_pkg::strip_resp_t exp_strip,
   input  wire                   exp_push,
   output int                    got_count,
   output int                    pass_count,
   output int                    fail_count,
   output int                    err_count
);
   import strm_pkg::*;

   strip_resp_t exp_q [$];     // strips still owed by the DUT, oldest first
   strip_resp_t head;
   strip_resp_t held;          // response shown while the master stalled
   logic        stalled;
   logic        cmd_seen;      // first command has transferred
   logic        after_xfer;
   logic        reset_done;
   int          err_r, err_w;
   int          test_num, test_strips, test_err0;

   assign err_count = err_r + err_w;

   // a test passes when no error showed up since the previous one ended
   task automatic report_test(input string what);
      if (err_r + err_w == test_err0) begin
         pass_count++;
         $display("test %0d %s: passed", test_num, what);
      end else begin
         fail_count++;
         $display("test %0d %s: failed", test_num, what);
      end
      test_num++;
      test_strips = 0;
      test_err0   = err_r + err_w;
   endtask

   // ============================================================
   // command side, memory clock
   // ============================================================
   always @(posedge wclk) begin
      if (rst) begin
         err_w      <= 0;
         cmd_seen   <= 1'b0;
         after_xfer <= 1'b0;
      end else begin
         if (!cmd_seen && !cmd_ready) begin   // reader must idle after reset
            $display("ERROR t=%0t: cmd_ready low after reset before any command", $time);
            err_w <= err_w + 1;
         end
         if (after_xfer && cmd_ready) begin   // burst has started so the port must close
            $display("ERROR t=%0t: cmd_ready high while a burst runs", $time);
            err_w <= err_w + 1;
         end
         after_xfer <= cmd_valid & cmd_ready;
         if (cmd_valid && cmd_ready) cmd_seen <= 1'b1;
      end
   end

   // ============================================================
   // response side, port clock
   // ============================================================
   always @(posedge rclk) begin
      if (rst) begin
         exp_q.delete();
         got_count  = 0;
         pass_count = 0;
         fail_count = 0;
         err_r      = 0;
         test_num   = 0;
         test_err0  = 0;
         test_strips = 0;
         stalled    = 1'b0;
         reset_done = 1'b0;
      end else begin
         // the reset state is test 0 and it closes with the first command
         if (cmd_seen && !reset_done) begin
            report_test("reset state");
            reset_done = 1'b1;
         end
         if (!cmd_seen && resp_valid) begin
            $display("ERROR t=%0t: resp_valid high before any command", $time);
            err_r++;
         end
         if (stalled && (!resp_valid || resp !== held)) begin
            $display("ERROR t=%0t: response changed while stalled, held adr=%h now adr=%h",
                     $time, held.adr, resp.adr);
            err_r++;
         end
         if (resp_valid && resp_ready) begin
            if (exp_q.size() == 0) begin
               $display("unexpected response at t=%0t: adr=%h arrived with no strip expected",
                        $time, resp.adr);
               err_r++;
            end else begin
               head = exp_q.pop_front();
               got_count++;
               test_strips++;
               if (resp !== head) begin
                  $display("ERROR t=%0t: expected tid=%h adr=%h dat=%h last=%b",
                           $time, head.tid, head.adr, head.dat, head.last);
                  $display("ERROR t=%0t: actual   tid=%h adr=%h dat=%h last=%b",
                           $time, resp.tid, resp.adr, resp.dat, resp.last);
                  err_r++;
               end
               if (head.last) report_test($sformatf("burst of %0d strips", test_strips));
            end
         end
         if (exp_push) exp_q.push_back(exp_strip);   // joins the queue behind this edge's compare
         stalled = resp_valid & ~resp_ready;
         held    = resp;
      end
   end

endmodule

`default_nettype wire

// File: test/tb_strm_read.sv
`default_nettype none

module tb_strm_read;
   import strm_pkg::*;

   typedef struct packed {
      addr_t adr;
      len_t  len;
      logic  rand_ready;   // random back-pressure on the response port
      logic  wait_done;    // drain this stream before the next command
   } cmd_entry_t;

   localparam int   NUM_CMDS = 8;
   localparam int   RDY_PAT  = 1024;
   localparam tid_t EXP_TID  = {6'h3f, 7'h00};   // top six bits set, transaction 0

   // ============================================================
   // command table
   // ============================================================
   cmd_entry_t cmd_table [NUM_CMDS] = '{
      '{32'h0000_0040, 6'd1,  1'b0, 1'b1},   // single strip
      '{32'h0000_0100, 6'd40, 1'b0, 1'b1},   // longer than the FIFO, master always ready
      '{32'h0000_0100, 6'd40, 1'b1, 1'b1},   // same strips under random stalls
      '{32'h0000_0300, 6'd5,  1'b0, 1'b0},   // back to back with the next one
      '{32'h0000_0480, 6'd7,  1'b1, 1'b0},
      '{32'h0000_0208, 6'd3,  1'b0, 1'b1},
      '{32'h1234_07c0, 6'd12, 1'b0, 1'b1},   // index 248 wraps past 255
      '{32'h0000_0010, 6'd0,  1'b0, 1'b1}    // zero length reads one strip
   };

   logic        rclk, wclk, rst;
   burst_cmd_t  cmd;
   logic        cmd_valid, cmd_ready;
   logic        load_en;
   ram_adr_t    load_adr;
   strip_t      load_dat;
   strip_resp_t resp;
   logic        resp_valid, resp_ready;
   strip_resp_t exp_strip;
   logic        exp_push;
   int          got_count, pass_count, fail_count, err_count;
   strip_t      image [RAM_DEPTH];   // copy of what went into the RAM
   logic        ready_pat [RDY_PAT];
   logic        rand_ready;
   int          seed;
   int          exp_total;

   strm_read_top dut_i (
      .rclk (rclk), .wclk (wclk), .rst (rst),
      .cmd (cmd), .cmd_valid (cmd_valid), .cmd_ready (cmd_ready),
      .load_en (load_en), .load_adr (load_adr), .load_dat (load_dat),
      .resp (resp), .resp_valid (resp_valid), .resp_ready (resp_ready)
   );

   strm_checker chk_i (
      .rclk (rclk), .wclk (wclk), .rst (rst),
      .cmd_valid (cmd_valid), .cmd_ready (cmd_ready),
      .resp (resp), .resp_valid (resp_valid), .resp_ready (resp_ready),
      .exp_strip (exp_strip), .exp_push (exp_push),
      .got_count (got_count), .pass_count (pass_count),
      .fail_count (fail_count), .err_count (err_count)
   );

   initial begin
      rclk = 1'b0;
      forever #5 rclk = ~rclk;
   end

   initial begin
      wclk = 1'b0;
      forever #7 wclk = ~wclk;   // memory clock, unrelated to rclk
   end

   function automatic int strip_count(input len_t len);
      return (len == '0) ? 1 : int'(len);
   endfunction

   function automatic int timeout_limit();
      int sum;
      sum = 0;
      for (int i = 0; i < NUM_CMDS; i++) sum += strip_count(cmd_table[i].len);
      return sum * 20 + 500;
   endfunction

   task automatic load_ram();
      for (int i = 0; i < RAM_DEPTH; i++) begin
         @(posedge wclk);
         #1;
         load_en  = 1'b1;
         load_adr = ram_adr_t'(i);
         load_dat = image[i];
      end
      @(posedge wclk);
      #1 load_en = 1'b0;
   endtask

   // strip k of a burst sits at index (adr + 8k) / 8 modulo the RAM depth
   task automatic push_expected(input cmd_entry_t e);
      int    n;
      addr_t a;
      n = strip_count(e.len);
      for (int k = 0; k < n; k++) begin
         a = e.adr + addr_t'(k * STRIP_BYTES);
         @(posedge rclk);
         #1;
         exp_strip.tid  = EXP_TID;
         exp_strip.adr  = a;
         exp_strip.dat  = image[ram_adr_t'((a / STRIP_BYTES) % RAM_DEPTH)];
         exp_strip.last = (k == n - 1);
         exp_push       = 1'b1;
      end
      @(posedge rclk);
      #1 exp_push = 1'b0;
      exp_total += n;
   endtask

   task automatic issue_cmd(input cmd_entry_t e);
      @(posedge wclk);
      #1;
      cmd.adr    = e.adr;
      cmd.len    = e.len;
      cmd_valid  = 1'b1;
      rand_ready = e.rand_ready;
      do @(posedge wclk); while (!cmd_ready);   // held until the reader takes it
      #1 cmd_valid = 1'b0;
   endtask

   task automatic wait_responses();
      while (got_count < exp_total) @(negedge rclk);
   endtask

   // response ready, replayed from a pattern fixed before the first command
   initial begin
      int k;
      k = 0;
      resp_ready = 1'b0;
      forever begin
         @(posedge rclk);
         #1 resp_ready = rand_ready ? ready_pat[k % RDY_PAT] : 1'b1;
         k++;
      end
   end

   initial begin
      int cycles;
      int limit;
      cycles = 0;
      limit  = timeout_limit();
      while (cycles < limit) begin
         @(posedge rclk);
         cycles++;
      end
      $display("timeout: stopped waiting for responses after %0d rclk cycles, got %0d of %0d",
               cycles, got_count, exp_total);
      $display(">>> FAIL");
      $finish;
   end

   // ============================================================
   // main sequence
   // ============================================================
   initial begin
      int r;
      rst        = 1'b1;
      cmd        = '0;
      cmd_valid  = 1'b0;
      load_en    = 1'b0;
      load_adr   = '0;
      load_dat   = '0;
      exp_strip  = '0;
      exp_push   = 1'b0;
      rand_ready = 1'b0;
      exp_total  = 0;
      seed       = 24;
      for (int i = 0; i < RAM_DEPTH; i++) image[i] = {$random(seed), $random(seed)};
      for (int i = 0; i < RDY_PAT; i++) begin
         r = $random(seed);
         ready_pat[i] = r[0] & r[1];   // ready one cycle in four, slower than the reader
      end
      repeat (8) @(posedge rclk);
      #1 rst = 1'b0;
      load_ram();
      for (int i = 0; i < NUM_CMDS; i++) begin
         push_expected(cmd_table[i]);
         issue_cmd(cmd_table[i]);
         if (cmd_table[i].wait_done) wait_responses();
      end
      wait_responses();
      repeat (50) @(posedge rclk);   // room for any stray response to show up
      $display("tests passed %0d failed %0d, errors %0d", pass_count, fail_count, err_count);
      if (fail_count == 0 && err_count == 0 && pass_count == NUM_CMDS + 1) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: verilog/strip_ram.sv
`default_nettype none

module strip_ram (
   input  wire                wclk,
   // load port, used while no burst runs
   input  wire                load_en,
   input  strm_pkg::ram_adr_t load_adr,
   input  strm_pkg::strip_t   load_dat,
   // read port, data one cycle after rd_en
   input  wire                rd_en,
   input  strm_pkg::ram_adr_t rd_adr,
   output strm_pkg::strip_t   rd_dat
);
   import strm_pkg::*;

   // ==========================================================
   // storage
   // ==========================================================
   strip_t mem [RAM_DEPTH];   // stands in for the DRAM

   always_ff @(posedge wclk) begin
      if (load_en) begin
         mem[load_adr] <= load_dat;
      end
   end

   // ==========================================================
   // read register
   // ==========================================================
   // holds its value between reads so the capture stage sees stable data
   always_ff @(posedge wclk) begin
      if (rd_en) begin
         rd_dat <= mem[rd_adr];   // exactly one cycle of latency
      end
   end

endmodule

`default_nettype wire

// File: verilog/strm_burst_reader.sv
`default_nettype none

module strm_burst_reader (
   input  wire                  wclk,
   input  wire                  rst,
   // burst command
   input  strm_pkg::burst_cmd_t cmd,
   input  wire                  cmd_valid,
   output logic                 cmd_ready,
   // flow control from the stream FIFO
   input  wire                  almost_full,
   // RAM read port
   output logic                 rd_en,
   output strm_pkg::ram_adr_t   rd_adr,
   // strip sideband, lined up with the RAM data
   output logic                 wr,
   output strm_pkg::addr_t      wadr,
   output logic                 last_strip
);
   import strm_pkg::*;

   reader_state_t state;
   addr_t         cur_adr;    // byte address of the next strip to read
   len_t          remaining;  // strips still to read
   logic          is_last;

   // ==========================================================
   // read issue
   // ==========================================================
   assign cmd_ready = (state == IDLE);
   assign rd_en     = (state == READ) & ~almost_full;    // stall while the FIFO is nearly full
   assign rd_adr    = cur_adr[STRIP_OFS +: RAM_DEPTH_LOG2];  // wraps at the top of the RAM
   assign is_last   = (remaining == len_t'(1));

   always_ff @(posedge wclk) begin
      if (rst) begin
         state     <= IDLE;
         cur_adr   <= '0;
         remaining <= '0;
      end else begin
         case (state)
            IDLE: begin
               if (cmd_valid) begin
                  cur_adr   <= cmd.adr;
                  // a zero length still reads one strip
                  remaining <= (cmd.len == '0) ? len_t'(1) : cmd.len;
                  state     <= READ;
               end
            end
            READ: begin
               if (rd_en) begin
                  cur_adr   <= cur_adr + addr_t'(STRIP_BYTES);
                  remaining <= remaining - len_t'(1);
                  if (is_last) begin
                     state <= IDLE;   // cmd_ready back up next cycle
                  end
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   // ==========================================================
   // delay stage
   // ==========================================================
   // one cycle to match the RAM read latency
   always_ff @(posedge wclk) begin
      if (rst) begin
         wr <= 1'b0;
      end else begin
         wr <= rd_en;
      end
   end

   always_ff @(posedge wclk) begin
      wadr       <= cur_adr;              // only meaningful while wr is high
      last_strip <= rd_en & is_last;
   end

endmodule

`default_nettype wire

// File: verilog/strm_read_top.sv
`default_nettype none

module strm_read_top (
   input  wire                   rclk,
   input  wire                   wclk,
   input  wire                   rst,
   // command port, memory clock
   input  strm_pkg::burst_cmd_t  cmd,
   input  wire                   cmd_valid,
   output logic                  cmd_ready,
   // RAM load port, memory clock
   input  wire                   load_en,
   input  strm_pkg::ram_adr_t    load_adr,
   input  strm_pkg::strip_t      load_dat,
   // response port, port clock
   output strm_pkg::strip_resp_t resp,
   output logic                  resp_valid,
   input  wire                   resp_ready
);
   import strm_pkg::*;

   // ==========================================================
   // internal nets, all in wclk
   // ==========================================================
   logic     rd_en;
   ram_adr_t rd_adr;
   strip_t   rd_dat;
   logic     wr;           // rd_en one cycle later
   addr_t    wadr;
   logic     last_strip;
   logic     almost_full;  // back-pressure from the stream FIFO

   strip_ram ram_i (
      .wclk     (wclk),
      .load_en  (load_en),
      .load_adr (load_adr),
      .load_dat (load_dat),
      .rd_en    (rd_en),
      .rd_adr   (rd_adr),
      .rd_dat   (rd_dat)
   );

   strm_burst_reader reader_i (
      .wclk        (wclk),
      .rst         (rst),
      .cmd         (cmd),
      .cmd_valid   (cmd_valid),
      .cmd_ready   (cmd_ready),
      .almost_full (almost_full),
      .rd_en       (rd_en),
      .rd_adr      (rd_adr),
      .wr          (wr),
      .wadr        (wadr),
      .last_strip  (last_strip)
   );

   // crosses the strips over to rclk
   strm_read_fifo fifo_i (
      .rst         (rst),
      .wclk        (wclk),
      .wr          (wr),
      .wadr        (wadr),
      .wdat        (rd_dat),
      .last_strip  (last_strip),
      .almost_full (almost_full),
      .rclk        (rclk),
      .resp        (resp),
      .resp_valid  (resp_valid),
      .resp_ready  (resp_ready)
   );

endmodule

`default_nettype wire
